//--- verilog/cpuDefinesPkg.sv
package cpuDefinesPkg;

    // first fetch after reset comes from the boot rom
    localparam logic [31:0] resetPc = 32'hbfc0_0000;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;    // word index inside the 256 MB region
    } jTypeT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;       // branch offset in words
    } iTypeT;

    // one instruction word, two decodings
    typedef union packed {
        jTypeT jType;
        iTypeT iType;
    } instrWordT;

    // redirect kind resolved in execute
    typedef enum logic [1:0] {
        brNone = 2'd0,
        brCond = 2'd1,          // beq, bne, bgez and friends
        brReg  = 2'd2           // jr, jalr
    } branchTypeT;

    // exception entry request from mem, codes 4..7 reserved
    typedef enum logic [2:0] {
        exNone    = 3'd0,
        exEret    = 3'd1,
        exVector  = 3'd2,
        exRefetch = 3'd3
    } exEntrySelT;

    // next pc source, same order as the eight-way mux
    typedef enum logic [2:0] {
        srcSeq     = 3'd0,
        srcJump    = 3'd1,
        srcEpc     = 3'd2,
        srcVector  = 3'd3,
        srcBranch  = 3'd4,
        srcReg     = 3'd5,
        srcRefetch = 3'd6
    } pcSourceT;

    typedef struct packed {
        logic addrError;        // pc not word aligned
        logic tlbRefill;        // tlb sits outside, held low
    } fetchExceptT;

endpackage

//--- verilog/fetchBusPkg.sv
package fetchBusPkg;

    // icache address split, 4 KB per way
    localparam int cacheTagBits    = 20;
    localparam int cacheIndexBits  = 8;
    localparam int cacheOffsetBits = 32 - cacheTagBits - cacheIndexBits;

    // request to the instruction cache
    // tag is physical, index and offset come straight from the virtual pc
    // since they sit below the page boundary
    typedef struct packed {
        logic [cacheTagBits-1:0]    tag;
        logic [cacheIndexBits-1:0]  index;
        logic [cacheOffsetBits-1:0] offset;
        logic                       isCached;
    } fetchReqT;

endpackage

//--- verilog/pcSelect.sv
`timescale 1ns/100ps

module pcSelect (
    input  logic                     clk,         // assertions only
    input  logic                     reset,       // assertions only
    input  cpuDefinesPkg::exEntrySelT exEntrySel,
    input  logic                     branchFlush,
    input  cpuDefinesPkg::branchTypeT branchType,
    input  logic                     immeJump,
    output cpuDefinesPkg::pcSourceT   pcSource
);

    import cpuDefinesPkg::*;

    // exceptions beat branches, branches beat decode jumps
    always_comb begin
        case (exEntrySel)
            exEret:    pcSource = srcEpc;
            exVector:  pcSource = srcVector;
            exRefetch: pcSource = srcRefetch;
            default: begin
                if (branchFlush && branchType == brReg) begin
                    pcSource = srcReg;
                end else if (branchFlush && branchType == brCond) begin
                    pcSource = srcBranch;
                end else if (immeJump) begin
                    pcSource = srcJump;  // older branch in exe already lost
                end else begin
                    pcSource = srcSeq;
                end
            end
        endcase
    end

    // mem stage must never send a reserved entry code
    entryCodeLegal: assert property (@(posedge clk) disable iff (reset)
        exEntrySel inside {exNone, exEret, exVector, exRefetch})
        else $error("reserved exception entry code %0d", exEntrySel);

    // a flush from execute always names what kind of redirect it is
    flushHasType: assert property (@(posedge clk) disable iff (reset)
        branchFlush |-> branchType != brNone)
        else $error("branch flush raised with no branch type");

endmodule

//--- verilog/targetCompute.sv
`timescale 1ns/100ps

module targetCompute (
    input  logic [31:0]              pc,
    input  logic [31:0]              idPc,
    input  cpuDefinesPkg::instrWordT idInstr,
    input  logic [31:0]              exePc,
    input  cpuDefinesPkg::instrWordT exeInstr,
    output logic [31:0]              seqPc,
    output logic [31:0]              jumpPc,
    output logic [31:0]              branchPc
);

    logic [31:0] idPcPlus4;      // delay slot address of the jump
    logic [31:0] branchOffset;

    assign seqPc = pc + 32'd4;

    // j / jal stay inside the region of the delay slot
    assign idPcPlus4 = idPc + 32'd4;
    assign jumpPc    = {idPcPlus4[31:28], idInstr.jType.target, 2'b00};

    // imm is in words, sign extend then scale
    assign branchOffset = {{14{exeInstr.iType.imm[15]}}, exeInstr.iType.imm, 2'b00};
    assign branchPc     = exePc + 32'd4 + branchOffset;

endmodule

//--- verilog/pcRegister.sv
`timescale 1ns/100ps

module pcRegister (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      pcWrite,     // low while the hazard unit stalls
    input  cpuDefinesPkg::pcSourceT    pcSource,
    input  logic [31:0]               seqPc,
    input  logic [31:0]               jumpPc,
    input  logic [31:0]               branchPc,
    input  logic [31:0]               busA,        // jr target
    input  logic [31:0]               epc,
    input  logic [31:0]               exceptionVector,
    input  logic [31:0]               memPc,
    input  logic [31:0]               physAddr,
    input  logic                      isCached,
    output logic [31:0]               pc,
    output fetchBusPkg::fetchReqT      fetchReq,
    output cpuDefinesPkg::fetchExceptT fetchExcept
);

    import cpuDefinesPkg::*;
    import fetchBusPkg::*;

    logic [31:0] nextPc;

    always_comb begin
        case (pcSource)
            srcJump:    nextPc = jumpPc;
            srcEpc:     nextPc = epc;
            srcVector:  nextPc = exceptionVector;
            srcBranch:  nextPc = branchPc;
            srcReg:     nextPc = busA;
            srcRefetch: nextPc = memPc;   // replay the instruction in mem
            default:    nextPc = seqPc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
        end else if (pcWrite) begin
            pc <= nextPc;
        end
    end

    // tag from the tlb, index and offset from the untranslated low bits
    assign fetchReq.tag      = physAddr[31 -: cacheTagBits];
    assign fetchReq.index    = pc[cacheOffsetBits +: cacheIndexBits];
    assign fetchReq.offset   = pc[cacheOffsetBits-1:0];
    assign fetchReq.isCached = isCached;

    assign fetchExcept.addrError = pc[1:0] != 2'b00;
    assign fetchExcept.tlbRefill = 1'b0;

    // a stall freezes the pc whatever the redirect inputs do
    pcHoldsOnStall: assert property (@(posedge clk) disable iff (reset)
        !pcWrite |=> $stable(pc))
        else $error("pc moved during a stall");

    // only a register jump or an exception address can misalign the pc
    arithTargetAligned: assert property (@(posedge clk) disable iff (reset)
        (pcWrite && pc[1:0] == 2'b00 && pcSource inside {srcSeq, srcJump, srcBranch})
        |=> pc[1:0] == 2'b00)
        else $error("arithmetic target left word alignment");

endmodule

//--- verilog/preFetchTop.sv
`timescale 1ns/100ps

module preFetchTop (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       pcWrite,
    // from mem
    input  cpuDefinesPkg::exEntrySelT  exEntrySel,
    input  logic [31:0]                epc,
    input  logic [31:0]                exceptionVector,
    input  logic [31:0]                memPc,
    // from execute
    input  logic                       branchFlush,
    input  cpuDefinesPkg::branchTypeT  branchType,
    input  logic [31:0]                exePc,
    input  cpuDefinesPkg::instrWordT   exeInstr,
    input  logic [31:0]                busA,
    // from decode
    input  logic                       immeJump,
    input  logic [31:0]                idPc,
    input  cpuDefinesPkg::instrWordT   idInstr,
    input  logic [31:0]                physAddr,    // from the tlb
    input  logic                       isCached,
    output logic [31:0]                pc,          // also the virtual address for the tlb
    output fetchBusPkg::fetchReqT       fetchReq,
    output cpuDefinesPkg::fetchExceptT  fetchExcept
);

    import cpuDefinesPkg::*;

    pcSourceT    pcSource;
    logic [31:0] seqPc;
    logic [31:0] jumpPc;
    logic [31:0] branchPc;

    pcSelect selectI (
        .clk         (clk),
        .reset       (reset),
        .exEntrySel  (exEntrySel),
        .branchFlush (branchFlush),
        .branchType  (branchType),
        .immeJump    (immeJump),
        .pcSource    (pcSource)
    );

    targetCompute targetI (
        .pc       (pc),
        .idPc     (idPc),
        .idInstr  (idInstr),
        .exePc    (exePc),
        .exeInstr (exeInstr),
        .seqPc    (seqPc),
        .jumpPc   (jumpPc),
        .branchPc (branchPc)
    );

    pcRegister registerI (
        .clk             (clk),
        .reset           (reset),
        .pcWrite         (pcWrite),
        .pcSource        (pcSource),
        .seqPc           (seqPc),
        .jumpPc          (jumpPc),
        .branchPc        (branchPc),
        .busA            (busA),
        .epc             (epc),
        .exceptionVector (exceptionVector),
        .memPc           (memPc),
        .physAddr        (physAddr),
        .isCached        (isCached),
        .pc              (pc),
        .fetchReq        (fetchReq),
        .fetchExcept     (fetchExcept)
    );

endmodule

//--- verif/preFetchTb.sv
`timescale 1ns/100ps

module preFetchTb;

    import cpuDefinesPkg::*;
    import fetchBusPkg::*;

    // one line of the stimulus file
    typedef struct packed {
        logic [7:0]  grp;
        logic [7:0]  randMask;         // bit n set, 32-bit field n comes from $random
        logic        pcWrite;
        logic [2:0]  exEntrySel;
        logic        branchFlush;
        logic [1:0]  branchType;
        logic        immeJump;
        logic [31:0] idPc;
        logic [31:0] idInstr;
        logic [31:0] exePc;
        logic [31:0] exeInstr;
        logic [31:0] busA;
        logic [31:0] epc;
        logic [31:0] exceptionVector;
        logic [31:0] memPc;
        logic [31:0] physAddr;
        logic        isCached;
        logic [31:0] expPc;
        logic [19:0] expTag;
        logic        expAddrErr;
    } stimVecT;

    logic        clk;
    logic        reset;
    logic        pcWrite;
    exEntrySelT  exEntrySel;
    logic [31:0] epc;
    logic [31:0] exceptionVector;
    logic [31:0] memPc;
    logic        branchFlush;
    branchTypeT  branchType;
    logic [31:0] exePc;
    instrWordT   exeInstr;
    logic [31:0] busA;
    logic        immeJump;
    logic [31:0] idPc;
    instrWordT   idInstr;
    logic [31:0] physAddr;
    logic        isCached;
    logic [31:0] pc;
    fetchReqT    fetchReq;
    fetchExceptT fetchExcept;

    stimVecT vecs[$];
    integer  seed = 32'h88f5;
    int      errors = 0;
    int      checks = 0;
    int      grpErrors = 0;
    int      grpChecks = 0;
    int      curVec = -1;
    bit      vecLoaded = 1'b0;

    preFetchTop dut_i (
        .clk             (clk),
        .reset           (reset),
        .pcWrite         (pcWrite),
        .exEntrySel      (exEntrySel),
        .epc             (epc),
        .exceptionVector (exceptionVector),
        .memPc           (memPc),
        .branchFlush     (branchFlush),
        .branchType      (branchType),
        .exePc           (exePc),
        .exeInstr        (exeInstr),
        .busA            (busA),
        .immeJump        (immeJump),
        .idPc            (idPc),
        .idInstr         (idInstr),
        .physAddr        (physAddr),
        .isCached        (isCached),
        .pc              (pc),
        .fetchReq        (fetchReq),
        .fetchExcept     (fetchExcept)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;   // 100 ns period

    task automatic loadVectors();
        int          fd;
        int          cnt;
        int          lineNo;
        string       line;
        logic [31:0] fld [0:19];
        stimVecT     v;
        fd = $fopen("verif/preFetchStim.txt", "r");
        lineNo = 0;
        if (fd == 0) begin
            $display("cannot open the stimulus file verif/preFetchStim.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            lineNo++;
            // comment and blank lines give no hex field
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8],
                fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15], fld[16],
                fld[17], fld[18], fld[19]);
            if (cnt == 20) begin
                v.grp             = fld[0][7:0];
                v.randMask        = fld[1][7:0];
                v.pcWrite         = fld[2][0];
                v.exEntrySel      = fld[3][2:0];
                v.branchFlush     = fld[4][0];
                v.branchType      = fld[5][1:0];
                v.immeJump        = fld[6][0];
                v.idPc            = fld[7];
                v.idInstr         = fld[8];
                v.exePc           = fld[9];
                v.exeInstr        = fld[10];
                v.busA            = fld[11];
                v.epc             = fld[12];
                v.exceptionVector = fld[13];
                v.memPc           = fld[14];
                v.physAddr        = fld[15];
                v.isCached        = fld[16][0];
                v.expPc           = fld[17];
                v.expTag          = fld[18][19:0];
                v.expAddrErr      = fld[19][0];
                vecs.push_back(v);
            end else if (cnt > 0) begin
                $display("stimulus line %0d is short, it has %0d of 20 fields", lineNo, cnt);
                $fclose(fd);
                return;
            end
        end
        $fclose(fd);
        if (vecs.size() == 0) begin
            $display("the stimulus file holds no vectors");
        end else begin
            vecLoaded = 1'b1;
        end
    endtask

    function automatic logic [31:0] fieldOrRandom(input logic [31:0] fileVal,
                                                  input logic useRandom);
        logic [31:0] val;
        if (useRandom) begin
            val = $random(seed);
        end else begin
            val = fileVal;
        end
        return val;
    endfunction

    function automatic string groupName(input logic [7:0] grp);
        case (grp)
            8'd1:    return "reset and sequential fetch";
            8'd2:    return "stall";
            8'd3:    return "jump and branch targets";
            8'd4:    return "redirect priority";
            8'd5:    return "fetch request";
            8'd6:    return "misaligned fetch";
            default: return "unnamed";
        endcase
    endfunction

    task automatic idleControl();
        pcWrite     = 1'b0;
        exEntrySel  = exNone;
        branchFlush = 1'b0;
        branchType  = brNone;
        immeJump    = 1'b0;
    endtask

    // everything sampled at the next edge
    task automatic applyControl(input stimVecT v);
        pcWrite         = v.pcWrite;
        exEntrySel      = exEntrySelT'(v.exEntrySel);
        branchFlush     = v.branchFlush;
        branchType      = branchTypeT'(v.branchType);
        immeJump        = v.immeJump;
        idPc            = fieldOrRandom(v.idPc, v.randMask[0]);
        idInstr         = fieldOrRandom(v.idInstr, v.randMask[1]);
        exePc           = fieldOrRandom(v.exePc, v.randMask[2]);
        exeInstr        = fieldOrRandom(v.exeInstr, v.randMask[3]);
        busA            = fieldOrRandom(v.busA, v.randMask[4]);
        epc             = fieldOrRandom(v.epc, v.randMask[5]);
        exceptionVector = fieldOrRandom(v.exceptionVector, v.randMask[6]);
        memPc           = fieldOrRandom(v.memPc, v.randMask[7]);
    endtask

    // tlb answer for the pc loaded by this vector, one cycle later
    task automatic applyTranslation(input stimVecT v);
        physAddr = v.physAddr;
        isCached = v.isCached;
    endtask

    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        checks++;
        grpChecks++;
        if (actVal !== expVal) begin
            $display("FAIL time %0t vector %0d %s expected %h got %h",
                     $time, curVec, name, expVal, actVal);
            errors++;
            grpErrors++;
        end
    endtask

    task automatic checkVector(input stimVecT v, input int idx);
        curVec = idx;
        checkValue("pc", v.expPc, pc);
        checkValue("fetchReq.tag", {12'd0, v.expTag}, {12'd0, fetchReq.tag});
        checkValue("fetchReq.index", {24'd0, v.expPc[11:4]}, {24'd0, fetchReq.index});
        checkValue("fetchReq.offset", {28'd0, v.expPc[3:0]}, {28'd0, fetchReq.offset});
        checkValue("fetchReq.isCached", {31'd0, v.isCached}, {31'd0, fetchReq.isCached});
        checkValue("fetchExcept.addrError", {31'd0, v.expAddrErr},
                   {31'd0, fetchExcept.addrError});
        checkValue("fetchExcept.tlbRefill", 32'd0, {31'd0, fetchExcept.tlbRefill});
    endtask

    task automatic reportGroup(input logic [7:0] grp);
        $display("group %0d %s: %0d checks, %0d errors",
                 grp, groupName(grp), grpChecks, grpErrors);
        grpChecks = 0;
        grpErrors = 0;
    endtask

    initial begin
        int nVec;
        reset = 1'b1;
        idleControl();
        idPc            = '0;
        idInstr         = '0;
        exePc           = '0;
        exeInstr        = '0;
        busA            = '0;
        epc             = '0;
        exceptionVector = '0;
        memPc           = '0;
        physAddr        = 32'h1fc0_0000;   // boot rom seen through kseg1
        isCached        = 1'b0;
        loadVectors();
        nVec = vecs.size();
        if (!vecLoaded) begin
            $display("ERRORS FOUND");
            $finish;
        end else begin
            repeat (8) @(posedge clk);
            #5 reset = 1'b0;
            #90;
            checkValue("pc", resetPc, pc);
            checkValue("fetchExcept", 32'd0, {30'd0, fetchExcept});
            // one vector per cycle, translation trails by one
            for (int i = 0; i <= nVec; i++) begin
                @(posedge clk);
                #5;
                if (i < nVec) begin
                    applyControl(vecs[i]);
                end else begin
                    idleControl();
                end
                if (i > 0) begin
                    applyTranslation(vecs[i-1]);
                end
                #90;   // 5 ns before the next edge
                if (i > 0) begin
                    checkVector(vecs[i-1], i - 1);
                    if (i == nVec || vecs[i].grp != vecs[i-1].grp) begin
                        reportGroup(vecs[i-1].grp);
                    end
                end
            end
            $display("summary: %0d vectors, %0d checks, %0d errors", nVec, checks, errors);
            if (errors == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

    // watchdog, sized by the vector count
    initial begin
        int watchLimit;
        wait (vecLoaded);
        watchLimit = (vecs.size() + 2) * 100 + 8 * 100 + 1000;
        #(watchLimit);
        $display("timeout: the run did not finish within %0d ns", watchLimit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- verif/preFetchStim.txt
# grp mask pcWrite exSel flush brType immeJump idPc idInstr exePc exeInstr busA epc excVector
# memPc physAddr isCached expPc expTag expAddrErr, mask bit n randomizes field n from idPc
# reset then sequential fetch
1 ff 1 0 0 0 0 0 0 0 0 0 0 0 0 1fc00004 0 bfc00004 1fc00 0
1 ff 1 0 0 0 0 0 0 0 0 0 0 0 0 1fc00008 0 bfc00008 1fc00 0
1 ff 1 0 0 0 0 0 0 0 0 0 0 0 0 1fc0000c 0 bfc0000c 1fc00 0
1 ff 1 0 0 0 0 0 0 0 0 0 0 0 0 1fc00010 0 bfc00010 1fc00 0
# stall with redirects pending
2 ff 0 0 0 0 1 0 0 0 0 0 0 0 0 1fc00010 0 bfc00010 1fc00 0
2 ff 0 0 1 2 0 0 0 0 0 0 0 0 0 1fc00010 0 bfc00010 1fc00 0
2 ff 0 2 0 0 0 0 0 0 0 0 0 0 0 1fc00010 0 bfc00010 1fc00 0
2 ff 1 0 0 0 0 0 0 0 0 0 0 0 0 1fc00014 0 bfc00014 1fc00 0
# j, jal across a region edge, beq back, bne forward, jr
3 fc 1 0 0 0 1 bfc00010 0bf00080 0 0 0 0 0 0 1fc00200 0 bfc00200 1fc00 0
3 fc 1 0 0 0 1 affffffc 0c000040 0 0 0 0 0 0 10000100 0 b0000100 10000 0
3 f3 1 0 1 1 0 0 0 b0000120 1022fff8 0 0 0 0 10000104 0 b0000104 10000 0
3 f3 1 0 1 1 0 0 0 b0000104 14220010 0 0 0 0 10000148 0 b0000148 10000 0
3 ef 1 0 1 2 0 0 0 0 0 80001000 0 0 0 00001000 1 80001000 00001 0
# eret, vector, refetch over branch and jump, then branch and jr over jump
4 df 1 1 1 1 1 0 0 0 0 0 80002000 0 0 00002000 1 80002000 00002 0
4 bf 1 2 1 2 1 0 0 0 0 0 0 80000180 0 00000180 1 80000180 00000 0
4 7f 1 3 1 1 1 0 0 0 0 0 0 0 80002004 00002004 1 80002004 00002 0
4 f3 1 0 1 1 1 0 0 80002000 10220004 0 0 0 0 00002014 1 80002014 00002 0
4 ef 1 0 1 2 1 0 0 0 0 80003000 0 0 0 00003000 1 80003000 00003 0
# tag from physAddr, index and offset from pc
5 ff 1 0 0 0 0 0 0 0 0 0 0 0 0 12345004 1 80003004 12345 0
5 ef 1 0 1 2 0 0 0 0 0 80003ffc 0 0 0 abcdeffc 0 80003ffc abcde 0
5 ff 1 0 0 0 0 0 0 0 0 0 0 0 0 76543000 1 80004000 76543 0
# jr to a misaligned address, then the exception vector clears it
6 ef 1 0 1 2 0 0 0 0 0 80004a62 0 0 0 00004a62 1 80004a62 00004 1
6 ff 1 0 0 0 0 0 0 0 0 0 0 0 0 00004a66 1 80004a66 00004 1
6 bf 1 2 0 0 0 0 0 0 0 0 0 80000180 0 00000180 1 80000180 00000 0
6 ff 1 0 0 0 0 0 0 0 0 0 0 0 0 00000184 1 80000184 00000 0

//--- sim.f
verilog/cpuDefinesPkg.sv
verilog/fetchBusPkg.sv
verilog/pcSelect.sv
verilog/targetCompute.sv
verilog/pcRegister.sv
verilog/preFetchTop.sv
verif/preFetchTb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
LINTFLAGS = --lint-only -Wall --timing --timescale 1ns/100ps
TOP      = preFetchTb
FILELIST = sim.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS     = NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
